//--- rtl/raster_params.svh
// Fixed widths for the rasterizer back end
// Attributes are 32 bit fixed point: tex S3.28, depth S1.30, color S7.24
// Coordinates are unsigned and never wrap; the walker flags an overrun

`ifndef RASTER_PARAMS_SVH
`define RASTER_PARAMS_SVH

// Attribute word, all plane registers share it
`define RR_ATTR_W       32

// Screen coordinate
`define RR_COORD_W      12

// Saturated outputs
`define RR_DEPTH_OUT_W  16
`define RR_COLOR_OUT_W  8

// tex_s, tex_t, depth_z, color_r
`define RR_NUM_ATTR     4

`endif

//--- rtl/raster_pkg.sv
// Command and plane register encodings of the rasterizer back end
// Plane register addresses are start, inc_x, inc_y per attribute

`default_nettype none

package raster_pkg;

    // Walking commands from the rasterizer
    typedef enum logic [2:0] {
        RR_CMD_NOP   = 3'd0,
        RR_CMD_INIT  = 3'd1,
        RR_CMD_X_INC = 3'd2,
        RR_CMD_X_DEC = 3'd3,
        RR_CMD_Y_INC = 3'd4
    } rr_cmd_t;

    // Plane registers, three per attribute
    typedef enum logic [3:0] {
        PR_TEX_S_START   = 4'd0,
        PR_TEX_S_INC_X   = 4'd1,
        PR_TEX_S_INC_Y   = 4'd2,
        PR_TEX_T_START   = 4'd3,
        PR_TEX_T_INC_X   = 4'd4,
        PR_TEX_T_INC_Y   = 4'd5,
        PR_DEPTH_Z_START = 4'd6,
        PR_DEPTH_Z_INC_X = 4'd7,
        PR_DEPTH_Z_INC_Y = 4'd8,
        PR_COLOR_R_START = 4'd9,
        PR_COLOR_R_INC_X = 4'd10,
        PR_COLOR_R_INC_Y = 4'd11  // Addresses 12 to 15 are unused
    } plane_reg_t;

endpackage

`default_nettype wire

//--- rtl/raster_ifs.sv
// Internal links from the stepper and the walker into the fragment merge
// step_valid is high for one enabled cycle per non-NOP command
// Payload is only meaningful while step_valid is high

`default_nettype none
`include "raster_params.svh"

////////////////////////////////////////////////////////////////////////////
// Current attribute values
////////////////////////////////////////////////////////////////////////////
interface attr_if;
    logic                  step_valid;
    logic [`RR_ATTR_W-1:0] tex_s;    // S3.28
    logic [`RR_ATTR_W-1:0] tex_t;    // S3.28
    logic [`RR_ATTR_W-1:0] depth_z;  // S1.30
    logic [`RR_ATTR_W-1:0] color_r;  // S7.24

    modport src (output step_valid, tex_s, tex_t, depth_z, color_r);
    modport dst (input  step_valid, tex_s, tex_t, depth_z, color_r);
endinterface

////////////////////////////////////////////////////////////////////////////
// Current pixel position
////////////////////////////////////////////////////////////////////////////
interface pos_if;
    logic                   step_valid;
    logic [`RR_COORD_W-1:0] x;
    logic [`RR_COORD_W-1:0] y;
    logic                   is_inside;  // Coverage of the pixel at x, y

    modport src (output step_valid, x, y, is_inside);
    modport dst (input  step_valid, x, y, is_inside);
endinterface

`default_nettype wire

//--- rtl/attr_stepper.sv
// Steps the four attributes along the rasterizer walk, one ce-cycle latency
// Plane registers are written at any edge, ce is ignored for cfg writes
// A plane write lands before a later INIT only if it is issued first
// All sums wrap; range handling is left to the fragment merge

`default_nettype none
`include "raster_params.svh"

module attr_stepper
    import raster_pkg::*;
(
    input  logic                  aclk,
    input  logic                  rst,
    input  logic                  ce,
    input  logic                  cmd_valid,
    input  rr_cmd_t               cmd,
    input  logic                  cfg_we,
    input  plane_reg_t            cfg_addr,
    input  logic [`RR_ATTR_W-1:0] cfg_data,
    attr_if.src                   attr
);

    localparam int NUM_PLANE = 3 * `RR_NUM_ATTR;

    // Per attribute: start, inc_x, inc_y
    logic [`RR_ATTR_W-1:0] plane_q [NUM_PLANE];
    // Order tex_s, tex_t, depth_z, color_r
    logic [`RR_ATTR_W-1:0] curr_q [`RR_NUM_ATTR];
    logic                  step_valid_q;
    logic                  cmd_step;

    assign cmd_step = cmd_valid &&
                      (cmd inside {RR_CMD_INIT, RR_CMD_X_INC, RR_CMD_X_DEC, RR_CMD_Y_INC});

    ////////////////////////////////////////////////////////////////////////////
    // Plane equation registers
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge aclk)
    begin
        if (cfg_we)
        begin
            plane_q[cfg_addr] <= cfg_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Attribute stepping
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            step_valid_q <= 1'b0;
            for (int i = 0; i < `RR_NUM_ATTR; i++)
            begin
                curr_q[i] <= '0;
            end
        end
        else if (ce)
        begin
            step_valid_q <= cmd_step;
            if (cmd_valid)
            begin
                for (int i = 0; i < `RR_NUM_ATTR; i++)
                begin
                    case (cmd)
                        RR_CMD_INIT:
                        begin
                            curr_q[i] <= plane_q[3 * i];
                        end
                        RR_CMD_X_INC:
                        begin
                            curr_q[i] <= curr_q[i] + plane_q[3 * i + 1];
                        end
                        RR_CMD_X_DEC:
                        begin
                            curr_q[i] <= curr_q[i] - plane_q[3 * i + 1];
                        end
                        RR_CMD_Y_INC:
                        begin
                            curr_q[i] <= curr_q[i] + plane_q[3 * i + 2];
                        end
                        default:
                        begin
                            curr_q[i] <= curr_q[i];  // NOP holds
                        end
                    endcase
                end
            end
        end
    end

    assign attr.step_valid = step_valid_q;
    assign attr.tex_s      = curr_q[0];
    assign attr.tex_t      = curr_q[1];
    assign attr.depth_z    = curr_q[2];
    assign attr.color_r    = curr_q[3];

    // Writes beyond the last plane register would be lost silently
    a_cfg_addr_range: assert property (
        @(posedge aclk) disable iff (rst)
        cfg_we |-> (int'(cfg_addr) < NUM_PLANE)
    );

endmodule

`default_nettype wire

//--- rtl/pixel_walker.sv
// Tracks the pixel coordinate under the rasterizer commands, one ce-cycle
// cmd_x and cmd_y are sampled only with INIT
// The walk must stay on screen; no wrap at 0 or at the coordinate maximum

`default_nettype none
`include "raster_params.svh"

module pixel_walker
    import raster_pkg::*;
(
    input  logic                   aclk,
    input  logic                   rst,
    input  logic                   ce,
    input  logic                   cmd_valid,
    input  rr_cmd_t                cmd,
    input  logic                   cmd_inside,
    input  logic [`RR_COORD_W-1:0] cmd_x,
    input  logic [`RR_COORD_W-1:0] cmd_y,
    pos_if.src                     pos
);

    logic [`RR_COORD_W-1:0] x_q;
    logic [`RR_COORD_W-1:0] y_q;
    logic                   inside_q;
    logic                   step_valid_q;
    logic                   cmd_step;

    assign cmd_step = cmd_valid &&
                      (cmd inside {RR_CMD_INIT, RR_CMD_X_INC, RR_CMD_X_DEC, RR_CMD_Y_INC});

    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            x_q          <= '0;
            y_q          <= '0;
            inside_q     <= 1'b0;
            step_valid_q <= 1'b0;
        end
        else if (ce)
        begin
            step_valid_q <= cmd_step;
            if (cmd_step)
            begin
                inside_q <= cmd_inside;  // Travels with its coordinate
            end
            if (cmd_valid)
            begin
                case (cmd)
                    RR_CMD_INIT:
                    begin
                        x_q <= cmd_x;
                        y_q <= cmd_y;
                    end
                    RR_CMD_X_INC: x_q <= x_q + 1'b1;
                    RR_CMD_X_DEC: x_q <= x_q - 1'b1;
                    RR_CMD_Y_INC: y_q <= y_q + 1'b1;
                    default:      x_q <= x_q;
                endcase
            end
        end
    end

    assign pos.step_valid = step_valid_q;
    assign pos.x          = x_q;
    assign pos.y          = y_q;
    assign pos.is_inside  = inside_q;

    // Rasterizer must not walk off the screen edges
    a_no_x_underflow: assert property (
        @(posedge aclk) disable iff (rst)
        (ce && cmd_valid && cmd == RR_CMD_X_DEC) |-> (x_q != '0)
    );
    a_no_x_overflow: assert property (
        @(posedge aclk) disable iff (rst)
        (ce && cmd_valid && cmd == RR_CMD_X_INC) |-> (x_q != '1)
    );
    a_no_y_overflow: assert property (
        @(posedge aclk) disable iff (rst)
        (ce && cmd_valid && cmd == RR_CMD_Y_INC) |-> (y_q != '1)
    );

endmodule

`default_nettype wire

//--- rtl/fragment_merge.sv
// Joins attribute and position steps into fragments, one ce-cycle latency
// Depth is clamped to [0, 1.0) of S1.30, color to [0, 1.0) of S7.24
// Fragment payload holds its last value while frag_valid is low

`default_nettype none
`include "raster_params.svh"

module fragment_merge
(
    input  logic                       aclk,
    input  logic                       rst,
    input  logic                       ce,
    attr_if.dst                        attr,
    pos_if.dst                         pos,
    output logic                       frag_valid,
    output logic [`RR_COORD_W-1:0]     frag_x,
    output logic [`RR_COORD_W-1:0]     frag_y,
    output logic [`RR_ATTR_W-1:0]      frag_tex_s,
    output logic [`RR_ATTR_W-1:0]      frag_tex_t,
    output logic [`RR_DEPTH_OUT_W-1:0] frag_depth,
    output logic [`RR_COLOR_OUT_W-1:0] frag_color_r
);

    // Position of the 1.0 bit in each format
    localparam int DEPTH_ONE = 30;  // S1.30
    localparam int COLOR_ONE = 24;  // S7.24

    logic hit;

    ////////////////////////////////////////////////////////////////////////////
    // Saturation
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [`RR_DEPTH_OUT_W-1:0] sat_depth(
        input logic [`RR_ATTR_W-1:0] z
    );
        if (z[`RR_ATTR_W-1])
            return '0;                                  // Negative
        if (z[DEPTH_ONE])
            return '1;                                  // 1.0 or more
        return z[DEPTH_ONE-1 -: `RR_DEPTH_OUT_W];
    endfunction

    function automatic logic [`RR_COLOR_OUT_W-1:0] sat_color(
        input logic [`RR_ATTR_W-1:0] c
    );
        if (c[`RR_ATTR_W-1])
            return '0;
        // Any integer bit set means 1.0 or more
        if (|c[`RR_ATTR_W-2:COLOR_ONE])
            return '1;
        return c[COLOR_ONE-1 -: `RR_COLOR_OUT_W];
    endfunction

    assign hit = attr.step_valid && pos.step_valid && pos.is_inside;

    always_ff @(posedge aclk)
    begin
        if (rst)
            frag_valid <= 1'b0;
        else if (ce)
            frag_valid <= hit;
    end

    always_ff @(posedge aclk)
    begin
        if (ce && hit)
        begin
            frag_x       <= pos.x;
            frag_y       <= pos.y;
            frag_tex_s   <= attr.tex_s;
            frag_tex_t   <= attr.tex_t;
            frag_depth   <= sat_depth(attr.depth_z);
            frag_color_r <= sat_color(attr.color_r);
        end
    end

    // Stepper and walker see the same command stream in lockstep
    a_steps_aligned: assert property (
        @(posedge aclk) disable iff (rst)
        ce |-> (attr.step_valid == pos.step_valid)
    );

endmodule

`default_nettype wire

//--- rtl/raster_step_top.sv
// Rasterizer back end: command stream in, shaded fragments out
// Latency is 2 ce-cycles from an accepted command to its fragment
// ce low stalls the whole pipeline; there is no other flow control
// cmd and cfg_addr carry the raster_pkg encodings

`default_nettype none
`include "raster_params.svh"

module raster_step_top
    import raster_pkg::*;
(
    input  logic                         aclk,
    input  logic                         rst,
    input  logic                         ce,
    // Rasterizer command stream
    input  logic                         cmd_valid,
    input  logic [$bits(rr_cmd_t)-1:0]   cmd,
    input  logic                         cmd_inside,
    input  logic [`RR_COORD_W-1:0]       cmd_x,
    input  logic [`RR_COORD_W-1:0]       cmd_y,
    // Plane register writes
    input  logic                         cfg_we,
    input  logic [$bits(plane_reg_t)-1:0] cfg_addr,
    input  logic [`RR_ATTR_W-1:0]        cfg_data,
    // Fragments
    output logic                         frag_valid,
    output logic [`RR_COORD_W-1:0]       frag_x,
    output logic [`RR_COORD_W-1:0]       frag_y,
    output logic [`RR_ATTR_W-1:0]        frag_tex_s,
    output logic [`RR_ATTR_W-1:0]        frag_tex_t,
    output logic [`RR_DEPTH_OUT_W-1:0]   frag_depth,
    output logic [`RR_COLOR_OUT_W-1:0]   frag_color_r
);

    attr_if u_attr_if ();
    pos_if  u_pos_if ();

    attr_stepper u_attr_stepper (
        .aclk      (aclk),
        .rst       (rst),
        .ce        (ce),
        .cmd_valid (cmd_valid),
        .cmd       (rr_cmd_t'(cmd)),
        .cfg_we    (cfg_we),
        .cfg_addr  (plane_reg_t'(cfg_addr)),
        .cfg_data  (cfg_data),
        .attr      (u_attr_if.src)
    );

    pixel_walker u_pixel_walker (
        .aclk       (aclk),
        .rst        (rst),
        .ce         (ce),
        .cmd_valid  (cmd_valid),
        .cmd        (rr_cmd_t'(cmd)),
        .cmd_inside (cmd_inside),
        .cmd_x      (cmd_x),
        .cmd_y      (cmd_y),
        .pos        (u_pos_if.src)
    );

    fragment_merge u_fragment_merge (
        .aclk         (aclk),
        .rst          (rst),
        .ce           (ce),
        .attr         (u_attr_if.dst),
        .pos          (u_pos_if.dst),
        .frag_valid   (frag_valid),
        .frag_x       (frag_x),
        .frag_y       (frag_y),
        .frag_tex_s   (frag_tex_s),
        .frag_tex_t   (frag_tex_t),
        .frag_depth   (frag_depth),
        .frag_color_r (frag_color_r)
    );

endmodule

`default_nettype wire

//--- bench/tb_raster_step.sv
// Testbench for raster_step_top; concurrent assertions compare with a model
// The model follows the stepping, walking and clamp rules, 2 ce-cycles deep
// Inputs change on the falling edge; ce is randomly low in the later walks
// Walks stay on screen, so the walker's edge assertions never fire

`default_nettype none
`include "raster_params.svh"

module tb_raster_step
    import raster_pkg::*;
();

    localparam int TIMEOUT = 200;  // Clock cycles per wait loop

    typedef struct packed {
        logic                       valid;
        logic [`RR_COORD_W-1:0]     x;
        logic [`RR_COORD_W-1:0]     y;
        logic [`RR_ATTR_W-1:0]      tex_s;
        logic [`RR_ATTR_W-1:0]      tex_t;
        logic [`RR_DEPTH_OUT_W-1:0] depth;
        logic [`RR_COLOR_OUT_W-1:0] color_r;
    } frag_t;

    logic                       aclk;
    logic                       rst;
    logic                       ce;
    logic                       cmd_valid;
    rr_cmd_t                    cmd;
    logic                       cmd_inside;
    logic [`RR_COORD_W-1:0]     cmd_x;
    logic [`RR_COORD_W-1:0]     cmd_y;
    logic                       cfg_we;
    plane_reg_t                 cfg_addr;
    logic [`RR_ATTR_W-1:0]      cfg_data;
    logic                       frag_valid;
    logic [`RR_COORD_W-1:0]     frag_x;
    logic [`RR_COORD_W-1:0]     frag_y;
    logic [`RR_ATTR_W-1:0]      frag_tex_s;
    logic [`RR_ATTR_W-1:0]      frag_tex_t;
    logic [`RR_DEPTH_OUT_W-1:0] frag_depth;
    logic [`RR_COLOR_OUT_W-1:0] frag_color_r;

    logic                       stall_en;
    logic [`RR_ATTR_W-1:0]      cfg_vals [3 * `RR_NUM_ATTR];
    // Model state
    logic [`RR_ATTR_W-1:0]      m_plane [3 * `RR_NUM_ATTR];
    logic [`RR_ATTR_W-1:0]      m_attr [`RR_NUM_ATTR];
    logic [`RR_COORD_W-1:0]     m_x;
    logic [`RR_COORD_W-1:0]     m_y;
    frag_t                      pipe [2];  // [1] is what the DUT shows now
    int                         mismatch_count = 0;
    int                         timeout_count = 0;
    int                         frag_seen = 0;
    int                         frag_expected = 0;

    raster_step_top u_dut (
        .aclk         (aclk),
        .rst          (rst),
        .ce           (ce),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .cmd_inside   (cmd_inside),
        .cmd_x        (cmd_x),
        .cmd_y        (cmd_y),
        .cfg_we       (cfg_we),
        .cfg_addr     (cfg_addr),
        .cfg_data     (cfg_data),
        .frag_valid   (frag_valid),
        .frag_x       (frag_x),
        .frag_y       (frag_y),
        .frag_tex_s   (frag_tex_s),
        .frag_tex_t   (frag_tex_t),
        .frag_depth   (frag_depth),
        .frag_color_r (frag_color_r)
    );

    always #10 aclk = ~aclk;

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [`RR_DEPTH_OUT_W-1:0] clamp_depth(input logic [31:0] z);
        if ($signed(z) < 0)
            return '0;
        if ($signed(z) >= 32'sh4000_0000)       // 1.0 in S1.30
            return '1;
        return z[29:14];
    endfunction

    function automatic logic [`RR_COLOR_OUT_W-1:0] clamp_color(input logic [31:0] c);
        if ($signed(c) < 0)
            return '0;
        if ($signed(c) >= 32'sh0100_0000)       // 1.0 in S7.24
            return 8'd255;
        return c[23:16];
    endfunction

    always @(posedge aclk)
    begin
        frag_t nxt;
        if (rst)
        begin
            m_x     = '0;
            m_y     = '0;
            pipe[0] <= '0;
            pipe[1] <= '0;
            for (int i = 0; i < `RR_NUM_ATTR; i++)
                m_attr[i] = '0;
        end
        else if (ce)
        begin
            if (frag_valid)
                frag_seen++;                    // Value from before this edge
            if (cmd_valid)
            begin
                for (int i = 0; i < `RR_NUM_ATTR; i++)
                begin
                    case (cmd)
                        RR_CMD_INIT:  m_attr[i] = m_plane[3 * i];
                        RR_CMD_X_INC: m_attr[i] = m_attr[i] + m_plane[3 * i + 1];
                        RR_CMD_X_DEC: m_attr[i] = m_attr[i] - m_plane[3 * i + 1];
                        RR_CMD_Y_INC: m_attr[i] = m_attr[i] + m_plane[3 * i + 2];
                        default: ;
                    endcase
                end
                case (cmd)
                    RR_CMD_INIT:
                    begin
                        m_x = cmd_x;
                        m_y = cmd_y;
                    end
                    RR_CMD_X_INC: m_x = m_x + 1'b1;
                    RR_CMD_X_DEC: m_x = m_x - 1'b1;
                    RR_CMD_Y_INC: m_y = m_y + 1'b1;
                    default: ;
                endcase
            end
            nxt.valid   = cmd_valid && (cmd != RR_CMD_NOP) && cmd_inside;
            nxt.x       = m_x;
            nxt.y       = m_y;
            nxt.tex_s   = m_attr[0];
            nxt.tex_t   = m_attr[1];
            nxt.depth   = clamp_depth(m_attr[2]);
            nxt.color_r = clamp_color(m_attr[3]);
            if (nxt.valid)
                frag_expected++;
            pipe[1] <= pipe[0];
            pipe[0] <= nxt;
        end
        if (cfg_we)
            m_plane[cfg_addr] = cfg_data;       // Seen by INIT from the next edge on
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////
    function automatic void report_mismatch(input string msg);
        mismatch_count++;
        $display("Mismatch at %0t: %s", $time, msg);
    endfunction

    a_valid_match: assert property (@(posedge aclk) disable iff (rst)
        frag_valid == pipe[1].valid)
        else report_mismatch("frag_valid differs from the model");
    a_coord_match: assert property (@(posedge aclk) disable iff (rst)
        frag_valid |-> (frag_x == pipe[1].x && frag_y == pipe[1].y))
        else report_mismatch("fragment coordinate differs from the model");
    a_tex_match: assert property (@(posedge aclk) disable iff (rst)
        frag_valid |-> (frag_tex_s == pipe[1].tex_s && frag_tex_t == pipe[1].tex_t))
        else report_mismatch("texture S or T differs from the model");
    a_depth_match: assert property (@(posedge aclk) disable iff (rst)
        frag_valid |-> (frag_depth == pipe[1].depth))
        else report_mismatch("saturated depth differs from the model");
    a_color_match: assert property (@(posedge aclk) disable iff (rst)
        frag_valid |-> (frag_color_r == pipe[1].color_r))
        else report_mismatch("saturated red differs from the model");
    a_hold_on_stall: assert property (@(posedge aclk) disable iff (rst)
        !ce |=> ($stable(frag_valid) && $stable(frag_x) && $stable(frag_y) &&
                 $stable(frag_tex_s) && $stable(frag_tex_t) &&
                 $stable(frag_depth) && $stable(frag_color_r)))
        else report_mismatch("fragment output moved while ce was low");

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic next_ce();
        return stall_en ? ($urandom_range(0, 2) != 0) : 1'b1;
    endfunction

    // Holds the command until an enabled edge takes it
    task automatic send_cmd(input rr_cmd_t c, input logic [`RR_COORD_W-1:0] x,
                            input logic [`RR_COORD_W-1:0] y);
        int waited;
        waited = 0;
        @(negedge aclk);
        ce         = next_ce();
        cfg_we     = 1'b0;
        cmd_valid  = 1'b1;
        cmd        = c;
        cmd_inside = ($urandom_range(0, 3) != 0);
        cmd_x      = (c == RR_CMD_INIT) ? x : `RR_COORD_W'($urandom);
        cmd_y      = (c == RR_CMD_INIT) ? y : `RR_COORD_W'($urandom);
        @(posedge aclk);
        while (!ce && waited < TIMEOUT)
        begin
            waited++;
            @(negedge aclk);
            ce = next_ce();
            @(posedge aclk);
        end
        if (!ce)
        begin
            timeout_count++;
            $display("Timeout at %0t: a command was never accepted", $time);
        end
    endtask

    task automatic write_plane(input plane_reg_t addr, input logic [`RR_ATTR_W-1:0] data);
        @(negedge aclk);
        ce        = next_ce();                  // In-flight steps keep moving
        cmd_valid = 1'b0;
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_data  = data;
        @(posedge aclk);
    endtask

    task automatic program_planes();
        for (int i = 0; i < 3 * `RR_NUM_ATTR; i++)
            write_plane(plane_reg_t'(i), cfg_vals[i]);
    endtask

    // Rows alternate X_INC and X_DEC, joined by Y_INC
    task automatic serpentine(input int x0, input int y0, input int cols, input int rows);
        send_cmd(RR_CMD_INIT, `RR_COORD_W'(x0), `RR_COORD_W'(y0));
        for (int r = 0; r < rows; r++)
        begin
            for (int c = 0; c < cols; c++)
                send_cmd((r % 2 == 0) ? RR_CMD_X_INC : RR_CMD_X_DEC, '0, '0);
            send_cmd(RR_CMD_Y_INC, '0, '0);
        end
    endtask

    task automatic random_walk(input int steps);
        int cx;
        int pick;
        rr_cmd_t c;
        cx = 3;
        send_cmd(RR_CMD_INIT, `RR_COORD_W'(cx), 12'd300);
        for (int n = 0; n < steps; n++)
        begin
            pick = $urandom_range(0, 4);
            c = (pick == 0) ? RR_CMD_NOP : (pick == 1) ? RR_CMD_X_INC :
                (pick == 2) ? RR_CMD_X_DEC : (pick == 3) ? RR_CMD_Y_INC : RR_CMD_X_INC;
            if (c == RR_CMD_X_DEC && cx == 0)
                c = RR_CMD_X_INC;               // Stay on screen
            cx = (c == RR_CMD_X_INC) ? cx + 1 : (c == RR_CMD_X_DEC) ? cx - 1 : cx;
            send_cmd(c, '0, '0);
        end
    endtask

    // Three enabled edges flush the 2-stage pipeline
    task automatic wait_drain();
        int enabled;
        int waited;
        enabled = 0;
        waited  = 0;
        while (enabled < 3 && waited < TIMEOUT)
        begin
            @(negedge aclk);
            ce        = next_ce();
            cmd_valid = 1'b0;
            cfg_we    = 1'b0;
            @(posedge aclk);
            if (ce)
                enabled++;
            waited++;
        end
        if (enabled < 3)
        begin
            timeout_count++;
            $display("Timeout at %0t: the pipeline did not drain", $time);
        end
    endtask

    initial
    begin
        aclk       = 1'b0;
        rst        = 1'b1;
        ce         = 1'b0;
        cmd_valid  = 1'b0;
        cmd        = RR_CMD_NOP;
        cmd_inside = 1'b0;
        cmd_x      = '0;
        cmd_y      = '0;
        cfg_we     = 1'b0;
        cfg_addr   = PR_TEX_S_START;
        cfg_data   = '0;
        stall_en   = 1'b0;
        void'($urandom(32'h42a6_1db1));
        repeat (8) @(posedge aclk);
        @(negedge aclk);
        rst = 1'b0;
        wait_drain();                           // Idle with no fragment yet

        // Depth crosses 1.0 and goes negative, red drops below 0 and passes 1.0
        cfg_vals = '{32'h0100_0000, 32'h0008_0000, 32'h0010_0000,
                     32'hF800_0000, 32'h0001_2345, 32'hFFFE_0000,
                     32'h3FE0_0000, 32'h0008_0000, 32'h8000_0000,
                     32'h0030_8000, 32'hFFF0_0000, 32'h0200_0000};
        program_planes();
        serpentine(10, 20, 6, 3);

        // New planes while the last fragments are still in flight
        stall_en = 1'b1;
        for (int i = 0; i < 3 * `RR_NUM_ATTR; i++)
            cfg_vals[i] = $urandom;
        program_planes();
        serpentine(400, 100, 5, 4);
        random_walk(80);
        wait_drain();

        if (frag_seen != frag_expected)
        begin
            mismatch_count++;
            $display("Mismatch at %0t: %0d fragments seen, %0d expected",
                     $time, frag_seen, frag_expected);
        end
        $display("Errors: %0d mismatches, %0d timeouts (%0d fragments checked)",
                 mismatch_count, timeout_count, frag_seen);
        if (mismatch_count == 0 && timeout_count == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- raster_step.f
+incdir+rtl
rtl/raster_pkg.sv
rtl/raster_ifs.sv
rtl/attr_stepper.sv
rtl/pixel_walker.sv
rtl/fragment_merge.sv
rtl/raster_step_top.sv
bench/tb_raster_step.sv

//--- Makefile
# Verilator build and run of the rasterizer back end testbench

SIM     ?= verilator
TOP     ?= tb_raster_step
FLIST   ?= raster_step.f
OBJ_DIR ?= obj_dir
VFLAGS  ?= --binary --timing --assert -Wno-fatal

BIN     := $(OBJ_DIR)/V$(TOP)
SRCS    := $(shell grep -v '^+' $(FLIST)) $(wildcard rtl/*.svh)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf $(OBJ_DIR)
